// File: list.f
source/region_pkg.sv
source/mem_port_if.sv
source/lsu_addr_demux.sv
source/ram_port_mux.sv
source/data_region.sv
verification/tb_ram_model.sv
verification/data_region_tb.sv

// File: source/data_region.sv
/*
 * Data region top: core load/store port, external bus port, slave port and RAM port.
 * Local window requests go to the data RAM, everything else to the external bus.
 */

`timescale 1ns/10ps

module data_region import region_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // core load/store port
  input  logic      lsu_req_i,
  input  addr_t     lsu_addr_i,
  input  logic      lsu_we_i,
  input  be_t       lsu_be_i,
  input  data_t     lsu_wdata_i,
  output logic      lsu_gnt_o,
  output logic      lsu_rvalid_o,
  output data_t     lsu_rdata_o,

  // external bus port
  output logic      ext_req_o,
  output addr_t     ext_addr_o,
  output logic      ext_we_o,
  output be_t       ext_be_o,
  output data_t     ext_wdata_o,
  input  logic      ext_gnt_i,
  input  logic      ext_rvalid_i,
  input  data_t     ext_rdata_i,

  // bus slave port into the data RAM
  input  logic      slv_req_i,
  input  ram_addr_t slv_addr_i,
  input  logic      slv_we_i,
  input  be_t       slv_be_i,
  input  data_t     slv_wdata_i,
  output data_t     slv_rdata_o,

  // data RAM
  output logic      ram_en_o,
  output ram_addr_t ram_addr_o,
  output logic      ram_we_o,
  output be_t       ram_be_o,
  output data_t     ram_wdata_o,
  input  data_t     ram_rdata_i
);

  mem_port_if lsu_port ();
  mem_port_if ext_port ();
  mem_port_if local_port ();

  // core side
  assign lsu_port.req   = lsu_req_i;
  assign lsu_port.addr  = lsu_addr_i;
  assign lsu_port.we    = lsu_we_i;
  assign lsu_port.be    = lsu_be_i;
  assign lsu_port.wdata = lsu_wdata_i;
  assign lsu_gnt_o      = lsu_port.gnt;
  assign lsu_rvalid_o   = lsu_port.rvalid;
  assign lsu_rdata_o    = lsu_port.rdata;

  // external side
  assign ext_req_o       = ext_port.req;
  assign ext_addr_o      = ext_port.addr;
  assign ext_we_o        = ext_port.we;
  assign ext_be_o        = ext_port.be;
  assign ext_wdata_o     = ext_port.wdata;
  assign ext_port.gnt    = ext_gnt_i;
  assign ext_port.rvalid = ext_rvalid_i;
  assign ext_port.rdata  = ext_rdata_i;

  lsu_addr_demux u_lsu_addr_demux (
    .clk       (clk),
    .rst_n     (rst_n),
    .lsu       (lsu_port),
    .local_mem (local_port),
    .ext       (ext_port)
  );

  ram_port_mux u_ram_port_mux (
    .clk         (clk),
    .rst_n       (rst_n),
    .slv_req_i   (slv_req_i),
    .slv_addr_i  (slv_addr_i),
    .slv_we_i    (slv_we_i),
    .slv_be_i    (slv_be_i),
    .slv_wdata_i (slv_wdata_i),
    .slv_rdata_o (slv_rdata_o),
    .core        (local_port),
    .ram_en_o    (ram_en_o),
    .ram_addr_o  (ram_addr_o),
    .ram_we_o    (ram_we_o),
    .ram_be_o    (ram_be_o),
    .ram_wdata_o (ram_wdata_o),
    .ram_rdata_i (ram_rdata_i)
  );

endmodule

// File: source/lsu_addr_demux.sv
/*
 * Splits core load/store requests between the local data RAM and the external bus.
 * Grant is combinational; a one-bit register steers the response back.
 */

`timescale 1ns/10ps

module lsu_addr_demux import region_pkg::*; (
  input logic clk,
  input logic rst_n,

  mem_port_if.responder lsu,
  mem_port_if.requester local_mem,
  mem_port_if.requester ext
);

  logic      is_local;
  resp_src_e resp_src_q;
  resp_src_e resp_src_d;

  // decode the upper address bits
  assign is_local = (lsu.addr[ADDR_W-1 -: REGION_MSB_W] == LOCAL_REGION);

  // exactly one side sees the request
  assign local_mem.req = lsu.req & is_local;
  assign ext.req       = lsu.req & ~is_local;

  // fields go to both sides unchanged
  assign local_mem.addr  = lsu.addr;
  assign local_mem.we    = lsu.we;
  assign local_mem.be    = lsu.be;
  assign local_mem.wdata = lsu.wdata;

  assign ext.addr  = lsu.addr;
  assign ext.we    = lsu.we;
  assign ext.be    = lsu.be;
  assign ext.wdata = lsu.wdata;

  // grant from the selected side, remember the target for the response
  always_comb begin
    resp_src_d = resp_src_q;
    lsu.gnt    = 1'b0;

    if (ext.req) begin
      lsu.gnt    = ext.gnt;
      resp_src_d = RESP_EXT;
    end else if (local_mem.req) begin
      lsu.gnt    = local_mem.gnt;
      resp_src_d = RESP_RAM;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= RESP_RAM;
    end else begin
      resp_src_q <= resp_src_d;
    end
  end

  // response path back to the core
  assign lsu.rdata  = (resp_src_q == RESP_EXT) ? ext.rdata : local_mem.rdata;
  // only one access is in flight, so the valids never overlap
  assign lsu.rvalid = ext.rvalid | local_mem.rvalid;

endmodule

// File: source/mem_port_if.sv
/*
 * Request/grant/valid memory port between blocks of the data region.
 * A requester holds its fields until granted; every accepted request gets one rvalid.
 */

`timescale 1ns/10ps

interface mem_port_if import region_pkg::*; ();

  // request side
  logic  req;
  addr_t addr;
  logic  we;
  be_t   be;
  data_t wdata;

  // response side
  logic  gnt;
  logic  rvalid;
  data_t rdata;

  modport requester (
    output req,
    output addr,
    output we,
    output be,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport responder (
    input  req,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface

// File: source/ram_port_mux.sv
/*
 * Puts the bus slave port and the core port onto the single-port data RAM.
 * The slave has fixed priority; core read data returns one cycle after grant.
 */

`timescale 1ns/10ps

module ram_port_mux import region_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // bus-side slave port, strobe only
  input  logic      slv_req_i,
  input  ram_addr_t slv_addr_i,
  input  logic      slv_we_i,
  input  be_t       slv_be_i,
  input  data_t     slv_wdata_i,
  output data_t     slv_rdata_o,

  mem_port_if.responder core,

  // single-port RAM
  output logic      ram_en_o,
  output ram_addr_t ram_addr_o,
  output logic      ram_we_o,
  output be_t       ram_be_o,
  output data_t     ram_wdata_o,
  input  data_t     ram_rdata_i
);

  ram_addr_t slv_addr_word;
  ram_addr_t core_addr;
  logic      core_rvalid_q;

  // slave addresses are word aligned
  assign slv_addr_word = {slv_addr_i[RAM_ADDR_W-1:BYTE_OFS_W], {BYTE_OFS_W{1'b0}}};

  // core sees only the RAM window offset
  assign core_addr = core.addr[RAM_ADDR_W-1:0];

  // core waits while the slave is active
  assign core.gnt = core.req & ~slv_req_i;

  assign ram_en_o = slv_req_i | core.req;

  always_comb begin
    if (slv_req_i) begin
      ram_addr_o  = slv_addr_word;
      ram_we_o    = slv_we_i;
      ram_be_o    = slv_be_i;
      ram_wdata_o = slv_wdata_i;
    end else begin
      ram_addr_o  = core_addr;
      ram_we_o    = core.we;
      ram_be_o    = core.be;
      ram_wdata_o = core.wdata;
    end
  end

  // RAM answers one cycle after enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_q <= 1'b0;
    end else begin
      core_rvalid_q <= core.gnt;
    end
  end

  assign core.rvalid = core_rvalid_q;

  // read word goes to both ports and each side knows when it is theirs
  assign core.rdata  = ram_rdata_i;
  assign slv_rdata_o = ram_rdata_i;

endmodule

// File: source/region_pkg.sv
/*
 * Shared widths, address window and types for the data region.
 * Imported by the RTL and the testbench.
 */

package region_pkg;

  // bus widths
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int BE_W       = DATA_W / 8;
  localparam int BYTE_OFS_W = 2;

  // 32 KiB data RAM, byte addressed
  localparam int RAM_ADDR_W = 15;

  // upper address bits that pick the local RAM window
  localparam int REGION_MSB_W = 12;
  localparam logic [REGION_MSB_W-1:0] LOCAL_REGION = 12'h001;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [BE_W-1:0]       be_t;
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

  // where the next core response comes from
  typedef enum logic {
    RESP_EXT = 1'b0,
    RESP_RAM = 1'b1
  } resp_src_e;

endpackage

// File: verification/data_region_tb.sv
/*
 * Directed testbench for the data region: reset, local RAM access, external routing,
 * slave priority, slave reads and LFSR-driven local traffic against a reference array.
 */

`timescale 1ns/10ps

module data_region_tb import region_pkg::*; ();

  // all tests together take well under 100 cycles
  localparam int MAX_CYCLES = 400;

  logic      clk;
  logic      rst_n;
  logic      lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o;
  addr_t     lsu_addr_i;
  be_t       lsu_be_i;
  data_t     lsu_wdata_i, lsu_rdata_o;
  logic      ext_req_o, ext_we_o, ext_gnt_i, ext_rvalid_i;
  addr_t     ext_addr_o;
  be_t       ext_be_o;
  data_t     ext_wdata_o, ext_rdata_i;
  logic      slv_req_i, slv_we_i;
  ram_addr_t slv_addr_i;
  be_t       slv_be_i;
  data_t     slv_wdata_i, slv_rdata_o;
  logic      ram_en_o, ram_we_o;
  ram_addr_t ram_addr_o;
  be_t       ram_be_o;
  data_t     ram_wdata_o, ram_rdata_i;

  data_t       ref_mem [0:2**(RAM_ADDR_W-BYTE_OFS_W)-1];
  logic [15:0] lfsr_q = 16'd23473;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  string       cur_test = "setup";

  data_region dut (.*);

  tb_ram_model u_ram (
    .clk     (clk),
    .en_i    (ram_en_o),
    .addr_i  (ram_addr_o),
    .we_i    (ram_we_o),
    .be_i    (ram_be_o),
    .wdata_i (ram_wdata_o),
    .rdata_o (ram_rdata_i)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: test %s did not finish within %0d cycles", cur_test, MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic check_data(input string what, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s/%s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s/%s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_ram_addr(input string what, input ram_addr_t exp,
                                input ram_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s/%s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_be(input string what, input be_t exp, input be_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s/%s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s/%s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output data_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[DATA_W-2:0], lfsr_q[0]};
    end
  endtask

  function automatic addr_t local_addr(input logic [RAM_ADDR_W-BYTE_OFS_W-1:0] idx);
    return {LOCAL_REGION, {(ADDR_W-REGION_MSB_W-RAM_ADDR_W){1'b0}}, idx, {BYTE_OFS_W{1'b0}}};
  endfunction

  // expected RAM contents after a byte-enabled write
  task automatic ref_write(input int idx, input be_t be, input data_t wdata);
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  // local access that is granted at once and answers one cycle later
  task automatic local_access(input addr_t addr, input logic we, input be_t be,
                              input data_t wdata, output data_t rdata);
    @(negedge clk);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    #1;
    check_bit("gnt", 1'b1, lsu_gnt_o);
    check_bit("ram_en", 1'b1, ram_en_o);
    check_bit("rvalid early", 1'b0, lsu_rvalid_o);
    @(negedge clk);
    check_bit("rvalid", 1'b1, lsu_rvalid_o);
    rdata     = lsu_rdata_o;
    lsu_req_i = 1'b0;
  endtask

  task automatic reset_test();
    cur_test = "reset";
    @(negedge clk);
    check_bit("ram_en", 1'b0, ram_en_o);
    check_bit("gnt", 1'b0, lsu_gnt_o);
    check_bit("rvalid", 1'b0, lsu_rvalid_o);
    check_bit("ext_req", 1'b0, ext_req_o);
  endtask

  task automatic local_rw_test();
    data_t rd;
    int    idx;
    idx      = 'h42;
    cur_test = "local write/read";
    local_access(local_addr(idx), 1'b1, 4'hf, 32'hcafe_f00d, rd);
    ref_write(idx, 4'hf, 32'hcafe_f00d);
    local_access(local_addr(idx), 1'b0, 4'hf, '0, rd);
    check_data("full word", ref_mem[idx], rd);
    cur_test = "local byte enables";
    local_access(local_addr(idx), 1'b1, 4'b0101, 32'h1122_3344, rd);
    ref_write(idx, 4'b0101, 32'h1122_3344);
    local_access(local_addr(idx), 1'b0, 4'hf, '0, rd);
    check_data("partial word", ref_mem[idx], rd);
  endtask

  task automatic ext_routing_test();
    cur_test = "external routing";
    @(negedge clk);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = 32'h8000_1230;
    lsu_we_i    = 1'b0;
    lsu_be_i    = 4'b0110;
    lsu_wdata_i = 32'h0bad_c0de;
    #1;
    check_bit("ext_req", 1'b1, ext_req_o);
    check_addr("ext_addr", 32'h8000_1230, ext_addr_o);
    check_bit("ext_we", 1'b0, ext_we_o);
    check_be("ext_be", 4'b0110, ext_be_o);
    check_data("ext_wdata", 32'h0bad_c0de, ext_wdata_o);
    check_bit("ram_en", 1'b0, ram_en_o);
    check_bit("gnt before ext_gnt", 1'b0, lsu_gnt_o);
    // hold the bus off for two cycles
    repeat (2) @(negedge clk);
    ext_gnt_i = 1'b1;
    #1;
    check_bit("gnt", 1'b1, lsu_gnt_o);
    @(negedge clk);
    lsu_req_i = 1'b0;
    ext_gnt_i = 1'b0;
    check_bit("rvalid early", 1'b0, lsu_rvalid_o);
    @(negedge clk);
    ext_rvalid_i = 1'b1;
    ext_rdata_i  = 32'h5a5a_0ff1;
    #1;
    check_bit("rvalid", 1'b1, lsu_rvalid_o);
    check_data("rdata", 32'h5a5a_0ff1, lsu_rdata_o);
    @(negedge clk);
    ext_rvalid_i = 1'b0;
  endtask

  task automatic slave_priority_test();
    int idx;
    idx      = 'h123;
    cur_test = "slave priority";
    @(negedge clk);
    slv_req_i   = 1'b1;
    slv_addr_i  = ram_addr_t'(local_addr(idx)) | ram_addr_t'(2'b11);
    slv_we_i    = 1'b1;
    slv_be_i    = 4'hf;
    slv_wdata_i = 32'hdead_beef;
    lsu_req_i   = 1'b1;
    lsu_addr_i  = local_addr(idx);
    lsu_we_i    = 1'b0;
    lsu_be_i    = 4'hf;
    #1;
    check_bit("core gnt", 1'b0, lsu_gnt_o);
    check_bit("ram_en", 1'b1, ram_en_o);
    check_bit("ram_we", 1'b1, ram_we_o);
    check_ram_addr("ram_addr aligned", ram_addr_t'(local_addr(idx)), ram_addr_o);
    ref_write(idx, 4'hf, 32'hdead_beef);
    @(negedge clk);
    slv_req_i = 1'b0;
    #1;
    check_bit("core gnt late", 1'b1, lsu_gnt_o);
    check_bit("rvalid early", 1'b0, lsu_rvalid_o);
    @(negedge clk);
    check_bit("rvalid", 1'b1, lsu_rvalid_o);
    check_data("rdata", ref_mem[idx], lsu_rdata_o);
    lsu_req_i = 1'b0;
  endtask

  task automatic slave_read_test();
    int idx;
    idx      = 'h42;
    cur_test = "slave read";
    @(negedge clk);
    slv_req_i  = 1'b1;
    slv_addr_i = ram_addr_t'(local_addr(idx)) | ram_addr_t'(2'b01);
    slv_we_i   = 1'b0;
    @(negedge clk);
    slv_req_i = 1'b0;
    check_data("slv_rdata", ref_mem[idx], slv_rdata_o);
    check_bit("core rvalid", 1'b0, lsu_rvalid_o);
  endtask

  task automatic random_traffic_test();
    int    idx_list [8];
    data_t rnd;
    data_t rd;
    cur_test = "random traffic";
    for (int i = 0; i < 8; i++) begin
      rand_bits(RAM_ADDR_W - BYTE_OFS_W, rnd);
      idx_list[i] = int'(rnd);
      rand_bits(DATA_W, rnd);
      local_access(local_addr(idx_list[i]), 1'b1, 4'hf, rnd, rd);
      ref_write(idx_list[i], 4'hf, rnd);
    end
    for (int i = 0; i < 8; i++) begin
      local_access(local_addr(idx_list[i]), 1'b0, 4'hf, '0, rd);
      check_data("read back", ref_mem[idx_list[i]], rd);
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_addr_i   = '0;
    lsu_we_i     = 1'b0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    slv_req_i    = 1'b0;
    slv_addr_i   = '0;
    slv_we_i     = 1'b0;
    slv_be_i     = '0;
    slv_wdata_i  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_test();
    local_rw_test();
    ext_routing_test();
    slave_priority_test();
    slave_read_test();
    random_traffic_test();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verification/tb_ram_model.sv
/*
 * Behavioral single-port data RAM for the testbench, byte enabled.
 * Read data appears one cycle after a read enable.
 */

`timescale 1ns/10ps

module tb_ram_model import region_pkg::*; (
  input  logic      clk,
  input  logic      en_i,
  input  ram_addr_t addr_i,
  input  logic      we_i,
  input  be_t       be_i,
  input  data_t     wdata_i,
  output data_t     rdata_o
);

  data_t                                mem [0:2**(RAM_ADDR_W-BYTE_OFS_W)-1];
  logic [RAM_ADDR_W-BYTE_OFS_W-1:0]     word_idx;
  data_t                                merged;

  assign word_idx = addr_i[RAM_ADDR_W-1:BYTE_OFS_W];

  // old word with the enabled bytes replaced
  always_comb begin
    merged = mem[word_idx];
    for (int b = 0; b < BE_W; b++) begin
      if (be_i[b]) begin
        merged[8*b +: 8] = wdata_i[8*b +: 8];
      end
    end
  end

  always @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[word_idx] <= merged;
      end else begin
        rdata_o <= mem[word_idx];
      end
    end
  end

endmodule
